/* src/led_matrix_pkg.sv */
`default_nettype none

package led_matrix_pkg;

    // matrix geometry
    localparam int PIXEL_WIDTH       = 16;
    localparam int PIXEL_HEIGHT      = 8;
    localparam int BYTES_PER_PIXEL   = 2;
    localparam int BRIGHTNESS_LEVELS = 6;

    localparam int ROW_BITS      = $clog2(PIXEL_HEIGHT);
    localparam int COL_BITS      = $clog2(PIXEL_WIDTH);
    localparam int PIXEL_BITS    = 8 * BYTES_PER_PIXEL;      // rgb565
    localparam int ROW_BYTES     = PIXEL_WIDTH * BYTES_PER_PIXEL;
    localparam int ROW_BYTE_BITS = $clog2(ROW_BYTES);

    // frame buffer banking, row[1:0] picks the bank
    localparam int NUM_BANKS      = 4;
    localparam int BANK_SEL_BITS  = $clog2(NUM_BANKS);
    localparam int BANK_ADDR_BITS = 6;                       // row hi, col, byte select
    localparam int BANK_ENTRIES   = 2 ** (BANK_ADDR_BITS - 1);

    // command bytes
    localparam logic [7:0] CMD_RED_ON     = "R";
    localparam logic [7:0] CMD_RED_OFF    = "r";
    localparam logic [7:0] CMD_GREEN_ON   = "G";
    localparam logic [7:0] CMD_GREEN_OFF  = "g";
    localparam logic [7:0] CMD_BLUE_ON    = "B";
    localparam logic [7:0] CMD_BLUE_OFF   = "b";
    localparam logic [7:0] CMD_PLANES_OFF = "0";
    localparam logic [7:0] CMD_PLANES_ON  = "9";
    localparam logic [7:0] CMD_PLANE_1    = "1";   // "1".."6" toggle one plane each
    localparam logic [7:0] CMD_LOAD_ROW   = "L";
    localparam logic [7:0] CMD_LOAD_PIXEL = "P";

    // byte_sel 0 is the high byte, sent first
    typedef struct packed {
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
        logic                byte_sel;
    } pixel_pos_t;

    typedef struct packed {
        pixel_pos_t pos;
        logic [7:0] data;
    } frame_write_t;

    // one read returns a whole pixel, so only the entry without byte select
    typedef struct packed {
        logic                      en;
        logic [BANK_ADDR_BITS-2:0] entry;
    } bank_read_t;

    typedef struct packed {
        logic [2:0]                   rgb_enable;        // bit 0 red
        logic [BRIGHTNESS_LEVELS-1:0] brightness_enable;
    } display_mask_t;

endpackage

`default_nettype wire

/* src/command_decoder.sv */
`default_nettype none

module command_decoder (
    input  wire logic                         clk_in,
    input  wire logic                         reset,
    input  wire logic [7:0]                   byte_in,
    input  wire logic                         byte_valid,
    input  wire logic                         row_done,
    input  wire led_matrix_pkg::frame_write_t row_write,
    input  wire logic                         row_we,
    input  wire logic                         pixel_done,
    input  wire led_matrix_pkg::frame_write_t pixel_write,
    input  wire logic                         pixel_we,
    output logic                              row_enable,
    output logic                              pixel_enable,
    output led_matrix_pkg::frame_write_t      frame_write,
    output logic [led_matrix_pkg::NUM_BANKS-1:0] bank_we,
    output led_matrix_pkg::display_mask_t     display_mask
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD_ROW,
        ST_LOAD_PIXEL
    } decoder_state_t;

    decoder_state_t state;

    logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] brightness_pending;
    logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] plane_toggle;
    logic [7:0]                                   plane_offset;

    led_matrix_pkg::frame_write_t sel_write;
    logic                         sel_we;
    logic                         sel_done;

    assign row_enable   = (state == ST_LOAD_ROW);
    assign pixel_enable = (state == ST_LOAD_PIXEL);

    // which of the six planes a digit byte refers to, "1" is the top plane
    always_comb begin
        plane_offset = byte_in - led_matrix_pkg::CMD_PLANE_1;
        plane_toggle = '0;
        for (int i = 0; i < led_matrix_pkg::BRIGHTNESS_LEVELS; i++) begin
            if (plane_offset == led_matrix_pkg::BRIGHTNESS_LEVELS - 1 - i) begin
                plane_toggle[i] = 1'b1;
            end
        end
    end

    // active loader
    always_comb begin
        sel_write = row_write;
        sel_we    = 1'b0;
        sel_done  = 1'b0;
        case (state)
            ST_LOAD_ROW: begin
                sel_we   = row_we;
                sel_done = row_done;
            end
            ST_LOAD_PIXEL: begin
                sel_write = pixel_write;
                sel_we    = pixel_we;
                sel_done  = pixel_done;
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (sel_we) begin
            frame_write <= sel_write;
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state                          <= ST_IDLE;
            bank_we                        <= '0;
            display_mask.rgb_enable        <= 3'b111;
            display_mask.brightness_enable <= '1;
            brightness_pending             <= '1;
        end else begin
            bank_we <= '0;
            if (sel_we) begin
                bank_we[sel_write.pos.row[led_matrix_pkg::BANK_SEL_BITS-1:0]] <= 1'b1;
            end

            if (byte_valid) begin
                // pending planes show up one byte late
                display_mask.brightness_enable <= brightness_pending;
                if (state == ST_IDLE) begin
                    case (byte_in)
                        led_matrix_pkg::CMD_RED_ON:     display_mask.rgb_enable[0] <= 1'b1;
                        led_matrix_pkg::CMD_RED_OFF:    display_mask.rgb_enable[0] <= 1'b0;
                        led_matrix_pkg::CMD_GREEN_ON:   display_mask.rgb_enable[1] <= 1'b1;
                        led_matrix_pkg::CMD_GREEN_OFF:  display_mask.rgb_enable[1] <= 1'b0;
                        led_matrix_pkg::CMD_BLUE_ON:    display_mask.rgb_enable[2] <= 1'b1;
                        led_matrix_pkg::CMD_BLUE_OFF:   display_mask.rgb_enable[2] <= 1'b0;
                        led_matrix_pkg::CMD_PLANES_OFF: brightness_pending <= '0;
                        led_matrix_pkg::CMD_PLANES_ON:  brightness_pending <= '1;
                        led_matrix_pkg::CMD_LOAD_ROW:   state <= ST_LOAD_ROW;
                        led_matrix_pkg::CMD_LOAD_PIXEL: state <= ST_LOAD_PIXEL;
                        default: begin
                            // toggle against the visible planes, not the pending ones
                            brightness_pending <= (brightness_pending & ~plane_toggle) |
                                (~display_mask.brightness_enable & plane_toggle);
                        end
                    endcase
                end else if (sel_done) begin
                    state <= ST_IDLE;   // last data byte only closes the command
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/row_loader.sv */
`default_nettype none

module row_loader (
    input  wire logic                    clk_in,
    input  wire logic                    reset,
    input  wire logic [7:0]              byte_in,
    input  wire logic                    byte_valid,
    input  wire logic                    enable,
    output led_matrix_pkg::frame_write_t write,
    output logic                         we,
    output logic                         done
);

    logic                                     have_row;
    logic [led_matrix_pkg::ROW_BITS-1:0]      row;
    logic [led_matrix_pkg::ROW_BYTE_BITS-1:0] byte_count;   // {col, byte_sel}

    // first byte after L is the row
    always_ff @(posedge clk_in) begin
        if (enable && byte_valid && !have_row) begin
            row <= byte_in[led_matrix_pkg::ROW_BITS-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset || !enable) begin
            have_row   <= 1'b0;
            byte_count <= '0;
        end else if (byte_valid) begin
            if (!have_row) begin
                have_row <= 1'b1;
            end else begin
                byte_count <= byte_count + 1'b1;
            end
        end
    end

    assign write.pos.row      = row;
    assign write.pos.col      = byte_count[led_matrix_pkg::ROW_BYTE_BITS-1:1];
    assign write.pos.byte_sel = byte_count[0];
    assign write.data         = byte_in;

    assign we   = enable && byte_valid && have_row;
    assign done = we && (&byte_count);    // low byte of the last column

endmodule

`default_nettype wire

/* src/pixel_loader.sv */
`default_nettype none

module pixel_loader (
    input  wire logic                    clk_in,
    input  wire logic                    reset,
    input  wire logic [7:0]              byte_in,
    input  wire logic                    byte_valid,
    input  wire logic                    enable,
    output led_matrix_pkg::frame_write_t write,
    output logic                         we,
    output logic                         done
);

    // 0 row, 1 col, 2 high byte, 3 low byte
    logic [1:0]                          step;
    logic [led_matrix_pkg::ROW_BITS-1:0] row;
    logic [led_matrix_pkg::COL_BITS-1:0] col;

    always_ff @(posedge clk_in) begin
        if (enable && byte_valid) begin
            if (step == 2'd0) begin
                row <= byte_in[led_matrix_pkg::ROW_BITS-1:0];
            end
            if (step == 2'd1) begin
                col <= byte_in[led_matrix_pkg::COL_BITS-1:0];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset || !enable) begin
            step <= 2'd0;
        end else if (byte_valid) begin
            step <= step + 2'd1;
        end
    end

    assign write.pos.row      = row;
    assign write.pos.col      = col;
    assign write.pos.byte_sel = step[0];
    assign write.data         = byte_in;

    assign we   = enable && byte_valid && step[1];
    assign done = we && step[0];

endmodule

`default_nettype wire

/* src/frame_bank.sv */
`default_nettype none

module frame_bank (
    input  wire logic                         clk_in,
    input  wire led_matrix_pkg::frame_write_t write,
    input  wire logic                         we,
    input  wire led_matrix_pkg::bank_read_t   read,
    output logic [led_matrix_pkg::PIXEL_BITS-1:0] read_data
);

    logic [led_matrix_pkg::PIXEL_BITS-1:0] mem [led_matrix_pkg::BANK_ENTRIES];
    logic [led_matrix_pkg::BANK_ADDR_BITS-2:0] write_entry;

    // low row bits already chose this bank
    assign write_entry = {write.pos.row[led_matrix_pkg::ROW_BITS-1:led_matrix_pkg::BANK_SEL_BITS],
                          write.pos.col};

    always_ff @(posedge clk_in) begin
        if (we) begin
            if (write.pos.byte_sel) begin
                mem[write_entry][7:0] <= write.data;
            end else begin
                mem[write_entry][15:8] <= write.data;   // high byte first
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (read.en) begin
            read_data <= mem[read.entry];
        end
    end

endmodule

`default_nettype wire

/* src/scan_reader.sv */
`default_nettype none

module scan_reader (
    input  wire logic                                clk_in,
    input  wire logic                                reset,
    input  wire logic                                read_strobe,
    input  wire logic [led_matrix_pkg::ROW_BITS-1:0] read_row,
    input  wire logic [led_matrix_pkg::COL_BITS-1:0] read_col,
    input  wire logic [led_matrix_pkg::PIXEL_BITS-1:0] bank_data [led_matrix_pkg::NUM_BANKS],
    input  wire led_matrix_pkg::display_mask_t       display_mask,
    output led_matrix_pkg::bank_read_t               read,
    output logic [led_matrix_pkg::PIXEL_BITS-1:0]    pixel_out,
    output logic                                     pixel_valid
);

    logic [led_matrix_pkg::BANK_SEL_BITS-1:0] bank_sel;
    logic                                     read_pending;
    logic [led_matrix_pkg::PIXEL_BITS-1:0]    raw_pixel;
    logic [4:0]                               red;
    logic [5:0]                               green;
    logic [4:0]                               blue;

    // same entry goes to every bank
    assign read.en    = read_strobe;
    assign read.entry = {read_row[led_matrix_pkg::ROW_BITS-1:led_matrix_pkg::BANK_SEL_BITS],
                         read_col};

    always_ff @(posedge clk_in) begin
        if (read_strobe) begin
            bank_sel <= read_row[led_matrix_pkg::BANK_SEL_BITS-1:0];
        end
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            read_pending <= 1'b0;
            pixel_valid  <= 1'b0;
        end else begin
            read_pending <= read_strobe;
            pixel_valid  <= read_pending;
        end
    end

    assign raw_pixel = bank_data[bank_sel];

    // red and blue only have five planes, so they drop the lowest one
    always_comb begin
        red   = display_mask.rgb_enable[0] ?
                (raw_pixel[15:11] & display_mask.brightness_enable[5:1]) : 5'd0;
        green = display_mask.rgb_enable[1] ?
                (raw_pixel[10:5] & display_mask.brightness_enable[5:0]) : 6'd0;
        blue  = display_mask.rgb_enable[2] ?
                (raw_pixel[4:0] & display_mask.brightness_enable[5:1]) : 5'd0;
    end

    always_ff @(posedge clk_in) begin
        if (read_pending) begin
            pixel_out <= {red, green, blue};
        end
    end

endmodule

`default_nettype wire

/* src/led_matrix_ctrl.sv */
`default_nettype none

module led_matrix_ctrl (
    input  wire logic                                clk_in,
    input  wire logic                                reset,
    input  wire logic [7:0]                          byte_in,
    input  wire logic                                byte_valid,
    input  wire logic                                read_strobe,
    input  wire logic [led_matrix_pkg::ROW_BITS-1:0] read_row,
    input  wire logic [led_matrix_pkg::COL_BITS-1:0] read_col,
    output logic [led_matrix_pkg::PIXEL_BITS-1:0]    pixel_out,
    output logic                                     pixel_valid,
    output logic [2:0]                               rgb_enable,
    output logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    logic                         row_enable;
    logic                         pixel_enable;
    led_matrix_pkg::frame_write_t row_write;
    led_matrix_pkg::frame_write_t pixel_write;
    logic                         row_we;
    logic                         pixel_we;
    logic                         row_done;
    logic                         pixel_done;

    led_matrix_pkg::frame_write_t             frame_write;
    logic [led_matrix_pkg::NUM_BANKS-1:0]     bank_we;
    led_matrix_pkg::bank_read_t               bank_read;
    logic [led_matrix_pkg::PIXEL_BITS-1:0]    bank_data [led_matrix_pkg::NUM_BANKS];
    led_matrix_pkg::display_mask_t            display_mask;

    command_decoder command_decoder_inst (
        .clk_in      (clk_in),
        .reset       (reset),
        .byte_in     (byte_in),
        .byte_valid  (byte_valid),
        .row_done    (row_done),
        .row_write   (row_write),
        .row_we      (row_we),
        .pixel_done  (pixel_done),
        .pixel_write (pixel_write),
        .pixel_we    (pixel_we),
        .row_enable  (row_enable),
        .pixel_enable(pixel_enable),
        .frame_write (frame_write),
        .bank_we     (bank_we),
        .display_mask(display_mask)
    );

    row_loader row_loader_inst (
        .clk_in    (clk_in),
        .reset     (reset),
        .byte_in   (byte_in),
        .byte_valid(byte_valid),
        .enable    (row_enable),
        .write     (row_write),
        .we        (row_we),
        .done      (row_done)
    );

    pixel_loader pixel_loader_inst (
        .clk_in    (clk_in),
        .reset     (reset),
        .byte_in   (byte_in),
        .byte_valid(byte_valid),
        .enable    (pixel_enable),
        .write     (pixel_write),
        .we        (pixel_we),
        .done      (pixel_done)
    );

    for (genvar i = 0; i < led_matrix_pkg::NUM_BANKS; i++) begin : g_bank
        frame_bank frame_bank_inst (
            .clk_in   (clk_in),
            .write    (frame_write),
            .we       (bank_we[i]),
            .read     (bank_read),
            .read_data(bank_data[i])
        );
    end

    scan_reader scan_reader_inst (
        .clk_in      (clk_in),
        .reset       (reset),
        .read_strobe (read_strobe),
        .read_row    (read_row),
        .read_col    (read_col),
        .bank_data   (bank_data),
        .display_mask(display_mask),
        .read        (bank_read),
        .pixel_out   (pixel_out),
        .pixel_valid (pixel_valid)
    );

    assign rgb_enable        = display_mask.rgb_enable;
    assign brightness_enable = display_mask.brightness_enable;

endmodule

`default_nettype wire

/* test/led_matrix_ctrl_checker.sv */
`default_nettype none

module led_matrix_ctrl_checker (
    input wire logic                                         clk_in,
    input wire logic                                         reset,
    input wire logic                                         read_strobe,
    input wire logic                                         pixel_valid,
    input wire logic [led_matrix_pkg::NUM_BANKS-1:0]         bank_we,
    input wire logic [2:0]                                   rgb_enable,
    input wire logic [led_matrix_pkg::BRIGHTNESS_LEVELS-1:0] brightness_enable
);

    // valid is the strobe delayed by two registers
    assert property (@(posedge clk_in) disable iff (reset)
        read_strobe |-> ##2 pixel_valid)
        else $error("pixel_valid missing two cycles after read_strobe");

    assert property (@(posedge clk_in) disable iff (reset)
        pixel_valid |-> $past(read_strobe, 2))
        else $error("pixel_valid without read_strobe two cycles earlier");

    assert property (@(posedge clk_in) disable iff (reset) $onehot0(bank_we))
        else $error("bank_we selects more than one bank");

    // values straight out of reset
    assert property (@(posedge clk_in)
        $past(reset) |-> (rgb_enable == 3'b111 && (&brightness_enable) && bank_we == '0
                          && !pixel_valid))
        else $error("outputs not at their reset values");

endmodule

bind led_matrix_ctrl led_matrix_ctrl_checker led_matrix_ctrl_checker_inst (.*);

`default_nettype wire

/* test/led_matrix_ctrl_tb.sv */
`default_nettype none

module led_matrix_ctrl_tb;

    localparam int PERIOD      = 4;
    localparam int ROW_READ    = 1 + 16 + 2;   // settle, 16 strobes, drain
    localparam int TEST_CYCLES = 16 + 4 + 8 * 34 + 8 * ROW_READ + 6 * (5 + ROW_READ)
                                 + 6 * (1 + ROW_READ) + 9 * (2 + ROW_READ) + 2 + 32 + 2
                                 + ROW_READ;
    localparam logic [8*6-1:0] CHANNEL_CMDS = "rgbRGB";
    localparam logic [8*9-1:0] PLANE_CMDS   = "316092459";

    logic        clk_in = 1'b0;
    logic        reset = 1'b1;
    logic [7:0]  byte_in = '0;
    logic        byte_valid = 1'b0;
    logic        read_strobe = 1'b0;
    logic [2:0]  read_row = '0;
    logic [3:0]  read_col = '0;
    logic [15:0] pixel_out;
    logic        pixel_valid;
    logic [2:0]  rgb_enable;
    logic [5:0]  brightness_enable;

    // reference model
    logic [15:0] frame_model [8][16];
    logic [2:0]  rgb_model = '1;
    logic [5:0]  bright_model = '1;
    logic [5:0]  pending_model = '1;
    logic [7:0]  load_cmd = '0;        // L or P while a load runs
    int          load_count = 0;
    logic [2:0]  load_row;
    logic [3:0]  load_col;
    logic [15:0] reads [$];            // expected pixels in flight
    logic [31:0] lfsr = 32'h6b798434;
    int          errors = 0;

    led_matrix_ctrl led_matrix_ctrl_inst (.*);

    always #(PERIOD / 2) clk_in = ~clk_in;

    function automatic logic [15:0] random_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // galois step
            v = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // red and blue see planes 5..1 and green all six
    function automatic logic [15:0] masked_pixel(input logic [15:0] p);
        logic [15:0] m;
        m = {{5{rgb_model[0]}} & bright_model[5:1], {6{rgb_model[1]}} & bright_model,
             {5{rgb_model[2]}} & bright_model[5:1]};
        return p & m;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic       loading;
        logic [5:0] next_bright;
        int         idx;
        loading     = (load_cmd != 8'd0);
        next_bright = pending_model;   // visible one byte late
        idx         = load_count - 1;
        if (load_cmd == "L") begin
            if (load_count == 0) begin
                load_row = b[2:0];
            end else begin
                frame_model[load_row][idx[4:1]][(idx[0] ? 7 : 15) -: 8] = b;
            end
        end else if (load_cmd == "P") begin
            case (load_count)
                0: load_row = b[2:0];
                1: load_col = b[3:0];
                default: frame_model[load_row][load_col][(load_count == 2 ? 15 : 7) -: 8] = b;
            endcase
        end else begin
            case (b)
                "R": rgb_model[0] = 1'b1;
                "r": rgb_model[0] = 1'b0;
                "G": rgb_model[1] = 1'b1;
                "g": rgb_model[1] = 1'b0;
                "B": rgb_model[2] = 1'b1;
                "b": rgb_model[2] = 1'b0;
                "0": pending_model = '0;
                "9": pending_model = '1;
                "1", "2", "3", "4", "5", "6": begin
                    idx = 6 - int'(b - 8'd48);   // digit 1 is the top plane
                    pending_model[idx] = ~bright_model[idx];
                end
                "L", "P": load_cmd = b;
                default: begin
                end
            endcase
        end
        if (loading) begin
            load_count++;
            if (load_count == (load_cmd == "L" ? 33 : 4)) begin
                load_cmd   = 8'd0;
                load_count = 0;
            end
        end
        bright_model = next_bright;
        byte_in      = b;
        byte_valid   = 1'b1;
        @(negedge clk_in);
        byte_valid = 1'b0;
        check_value("rgb_enable", rgb_model, rgb_enable);
        check_value("brightness_enable", bright_model, brightness_enable);
    endtask

    task automatic send_pixel(input logic [2:0] row, input logic [3:0] col,
                              input logic [15:0] value);
        send_byte("P");
        send_byte({5'd0, row});
        send_byte({4'd0, col});
        send_byte(value[15:8]);
        send_byte(value[7:0]);
    endtask

    task automatic issue_read(input logic [2:0] row, input logic [3:0] col);
        reads.push_back(masked_pixel(frame_model[row][col]));
        read_strobe = 1'b1;
        read_row    = row;
        read_col    = col;
        @(negedge clk_in);
        read_strobe = 1'b0;
    endtask

    task automatic drain_reads();
        repeat (2) @(negedge clk_in);   // two cycle read latency
        assert (reads.size() == 0) else begin
            $display("%0d pixel reads never returned pixel_valid", reads.size());
            errors++;
            reads.delete();
        end
    endtask

    task automatic read_back_row(input logic [2:0] row);
        @(negedge clk_in);   // last frame write lands
        for (int c = 0; c < 16; c++) begin
            issue_read(row, c[3:0]);
        end
        drain_reads();
    endtask

    always @(negedge clk_in) begin
        if (!reset && pixel_valid) begin
            assert (reads.size() != 0) else begin
                $display("pixel_valid came without any read outstanding");
                errors++;
            end
            if (reads.size() != 0) begin
                check_value("pixel_out", reads.pop_front(), pixel_out);
            end
        end
    end

    initial begin
        logic [2:0] row;
        repeat (16) @(negedge clk_in);
        reset = 1'b0;
        check_value("rgb_enable", 3'b111, rgb_enable);
        check_value("brightness_enable", 6'h3f, brightness_enable);
        repeat (4) begin
            @(negedge clk_in);
            check_value("pixel_valid", 0, pixel_valid);
        end

        // whole frame through L, then every pixel back
        for (int r = 0; r < 8; r++) begin
            send_byte("L");
            send_byte(8'(r));
            repeat (32) send_byte(8'(random_bits(8)));
        end
        for (int r = 0; r < 8; r++) begin
            read_back_row(3'(r));
        end

        repeat (6) begin
            row = 3'(random_bits(3));
            send_pixel(row, 4'(random_bits(4)), random_bits(16));
            read_back_row(row);   // neighbors unchanged
        end

        for (int i = 0; i < 6; i++) begin
            send_byte(CHANNEL_CMDS[8 * (5 - i) +: 8]);
            read_back_row(3'(i));
        end

        for (int i = 0; i < 9; i++) begin
            row = 3'(random_bits(3));
            send_byte(PLANE_CMDS[8 * (8 - i) +: 8]);
            send_byte("x");   // unknown byte brings the planes out
            read_back_row(row);
        end
        send_byte("#");
        send_byte("7");

        // reads every cycle while bytes stream in
        fork
            for (int i = 0; i < 32; i++) begin
                issue_read(3'd2, 4'(i));
            end
            begin
                send_pixel(3'd5, 4'(random_bits(4)), random_bits(16));
                repeat (8) send_byte("x");
            end
        join
        drain_reads();
        read_back_row(3'd5);

        $display("closing: %0d errors", errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(2 * TEST_CYCLES * PERIOD);
        $display("timeout: run did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
src/led_matrix_pkg.sv
src/command_decoder.sv
src/row_loader.sv
src/pixel_loader.sv
src/frame_bank.sv
src/scan_reader.sv
src/led_matrix_ctrl.sv
test/led_matrix_ctrl_checker.sv
test/led_matrix_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the led matrix testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module led_matrix_ctrl_tb --Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vled_matrix_ctrl_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
